/* verilog.f */
source/ntps_pkg.sv
source/pps_sync.sv
source/ntp_clock.sv
source/timestamp_server.sv
source/ntps_core.sv
dv/ntps_tb.sv

/* dv/ntps_tb.sv */
// NTP core testbench

module ntps_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import ntps_pkg::*;

  localparam ntp_frac_t FRAC_STEP      = 32'h0400_0000;
  localparam int        PPS_MIN_CYCLES = 3;
  localparam ntp_frac_t SYNC_TOL       = 32'h1000_0000;
  localparam int        PPS_TIMEOUT    = 100;
  localparam int        SEC_CYCLES     = 64;
  localparam int        RESET_CYCLES   = 8;
  localparam int        CLK_PERIOD     = 4;
  // Reset, five tests, margin
  localparam int        BUDGET_CYCLES  = RESET_CYCLES + 40 + 150 + 40 + 400 + 700 + 100;

  logic        clk156;
  logic        rst_n;
  logic        pps_a;
  logic        pps_b;
  logic        sec_set;
  ntp_sec_t    sec_value;
  logic        ts_req;
  logic        ts_ack;
  ntp_time_t   ts_time;
  clk_sel_t    ts_source;
  logic        ts_synced;
  logic        sync_ok_a;
  logic        sync_ok_b;

  int unsigned cycle_cnt;
  int unsigned release_cycle;
  int unsigned lcg_state;
  ntp_sec_t    loaded_sec;
  int          mismatch_count;
  int          problem_count;

  ntps_core #(
    .FRAC_STEP      (FRAC_STEP),
    .PPS_MIN_CYCLES (PPS_MIN_CYCLES),
    .SYNC_TOL       (SYNC_TOL),
    .PPS_TIMEOUT    (PPS_TIMEOUT)
  ) DUT (
    .clk156    (clk156),
    .rst_n     (rst_n),
    .pps_a     (pps_a),
    .pps_b     (pps_b),
    .sec_set   (sec_set),
    .sec_value (sec_value),
    .ts_req    (ts_req),
    .ts_ack    (ts_ack),
    .ts_time   (ts_time),
    .ts_source (ts_source),
    .ts_synced (ts_synced),
    .sync_ok_a (sync_ok_a),
    .sync_ok_b (sync_ok_b)
  );

  always #(CLK_PERIOD / 2) clk156 = ~clk156;

  // Index of the last rising edge
  always @(posedge clk156) begin
    cycle_cnt = cycle_cnt + 1;
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Fail at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
    mismatch_count++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    problem_count++;
  endtask

  // Returns 1 ns after the next rising edge
  task automatic next_cycle();
    @(posedge clk156);
    #1;
  endtask

  task automatic wait_until_cycle(input int unsigned target);
    while (cycle_cnt < target) next_cycle();
  endtask

  task automatic pps_pulse(input logic to_a, input logic to_b, input int width);
    pps_a = to_a;
    pps_b = to_b;
    repeat (width) next_cycle();
    pps_a = 1'b0;
    pps_b = 1'b0;
  endtask

  // One 4-cycle pulse followed by idle until the period is over
  task automatic run_period(input logic to_a, input logic to_b, input int period);
    int unsigned start;
    start = cycle_cnt;
    pps_pulse(to_a, to_b, 4);
    wait_until_cycle(start + period);
  endtask

  // Full four-phase exchange that returns the captured values and the capture edge
  task automatic request_timestamp(output ntp_time_t t, output clk_sel_t src,
                                   output logic syn, output int unsigned cap);
    int edges;
    ts_req = 1'b1;
    next_cycle();
    edges = 1;
    while (!ts_ack && edges < 10) begin
      next_cycle();
      edges++;
    end
    if (!ts_ack) report_problem("ts_ack never rose after a request");
    else if (edges != 1) report_problem("ts_ack rose later than one edge after ts_req");
    t = ts_time;
    src = ts_source;
    syn = ts_synced;
    cap = cycle_cnt;
    ts_req = 1'b0;
    next_cycle();
    edges = 1;
    while (ts_ack && edges < 10) begin
      next_cycle();
      edges++;
    end
    if (ts_ack) report_problem("ts_ack never fell after ts_req was released");
    else if (edges != 1) report_problem("ts_ack fell later than one edge after ts_req");
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_reset_handshake();
    ntp_time_t   t;
    ntp_time_t   held;
    ntp_time_t   exp;
    clk_sel_t    src;
    logic        syn;
    int unsigned cap;
    int          hold;
    if (ts_ack !== 1'b0) report_mismatch("ts_ack", ts_ack, 0);
    if (sync_ok_a !== 1'b0) report_mismatch("sync_ok_a", sync_ok_a, 0);
    if (sync_ok_b !== 1'b0) report_mismatch("sync_ok_b", sync_ok_b, 0);
    request_timestamp(t, src, syn, cap);
    // Time counts from zero at the first edge out of reset
    exp = 64'(cap - release_cycle - 1) * 64'(FRAC_STEP);
    if (t !== exp) report_mismatch("ts_time", t, exp);
    if (src !== CLK_A) report_mismatch("ts_source", src, CLK_A);
    if (syn !== 1'b0) report_mismatch("ts_synced", syn, 0);
    hold = 3 + int'(next_rand() % 6);
    ts_req = 1'b1;
    next_cycle();
    if (ts_ack !== 1'b1) report_mismatch("ts_ack", ts_ack, 1);
    held = ts_time;
    repeat (hold) begin
      next_cycle();
      if (ts_ack !== 1'b1) report_mismatch("ts_ack", ts_ack, 1);
      if (ts_time !== held) report_mismatch("ts_time", ts_time, held);
    end
    ts_req = 1'b0;
    next_cycle();
    if (ts_ack !== 1'b0) report_mismatch("ts_ack", ts_ack, 0);
  endtask

  task automatic test_counting();
    ntp_time_t   t1;
    ntp_time_t   t2;
    ntp_time_t   exp;
    clk_sel_t    src;
    logic        syn;
    int unsigned c1;
    int unsigned c2;
    int          gap;
    gap = 5 + int'(next_rand() % 40);
    request_timestamp(t1, src, syn, c1);
    repeat (gap) next_cycle();
    request_timestamp(t2, src, syn, c2);
    exp = t1 + 64'(c2 - c1) * 64'(FRAC_STEP);
    if (t2 !== exp) report_mismatch("ts_time", t2, exp);
    // Second capture exactly one second later
    request_timestamp(t1, src, syn, c1);
    wait_until_cycle(c1 + SEC_CYCLES - 1);
    request_timestamp(t2, src, syn, c2);
    if (c2 - c1 != SEC_CYCLES) report_problem("second capture was not one second later");
    if (t2.sec !== ntp_sec_t'(t1.sec + 1)) report_mismatch("ts_time.sec", t2.sec, t1.sec + 1);
    if (t2.frac !== t1.frac) report_mismatch("ts_time.frac", t2.frac, t1.frac);
  endtask

  task automatic test_seconds_load();
    ntp_time_t   t0;
    ntp_time_t   t1;
    ntp_time_t   exp;
    clk_sel_t    src;
    logic        syn;
    int unsigned c0;
    int unsigned c1;
    int unsigned start;
    ntp_sec_t    val;
    request_timestamp(t0, src, syn, c0);
    val = next_rand();
    loaded_sec = val;
    sec_set = 1'b1;
    sec_value = val;
    next_cycle();
    sec_set = 1'b0;
    request_timestamp(t1, src, syn, c1);
    exp = t0 + 64'(c1 - c0) * 64'(FRAC_STEP);
    if (t1.sec !== exp.sec) report_mismatch("ts_time.sec", t1.sec, exp.sec);
    start = cycle_cnt;
    pps_pulse(1'b1, 1'b0, 4);
    wait_until_cycle(start + 10);
    request_timestamp(t1, src, syn, c1);
    if (src !== CLK_A) report_mismatch("ts_source", src, CLK_A);
    if (t1.sec !== val) report_mismatch("ts_time.sec", t1.sec, val);
    // The event comes PPS_MIN_CYCLES + 2 edges after the first high sample
    if (64'(t1.frac) >= 64'(c1 - start - PPS_MIN_CYCLES - 3) * 64'(FRAC_STEP))
      report_problem("clock A fraction too large after the PPS event");
    // First event after reset is never in sync
    if (sync_ok_a !== 1'b0) report_mismatch("sync_ok_a", sync_ok_a, 0);
  endtask

  task automatic test_glitch_and_sync();
    ntp_time_t   t1;
    ntp_time_t   t2;
    ntp_time_t   exp;
    clk_sel_t    src;
    logic        syn;
    int unsigned c1;
    int unsigned c2;
    int          i;
    request_timestamp(t1, src, syn, c1);
    pps_pulse(1'b1, 1'b0, 2);
    repeat (10) next_cycle();
    request_timestamp(t2, src, syn, c2);
    exp = t1 + 64'(c2 - c1) * 64'(FRAC_STEP);
    if (t2 !== exp) report_mismatch("ts_time", t2, exp);
    if (sync_ok_a !== 1'b0) report_mismatch("sync_ok_a", sync_ok_a, 0);
    for (i = 0; i < 3; i++) begin
      run_period(1'b1, 1'b0, SEC_CYCLES);
      if (i > 0 && sync_ok_a !== 1'b1) report_mismatch("sync_ok_a", sync_ok_a, 1);
    end
    // This pulse is on time but the next one comes 20 cycles early
    run_period(1'b1, 1'b0, SEC_CYCLES - 20);
    if (sync_ok_a !== 1'b1) report_mismatch("sync_ok_a", sync_ok_a, 1);
    run_period(1'b1, 1'b0, SEC_CYCLES);
    if (sync_ok_a !== 1'b0) report_mismatch("sync_ok_a", sync_ok_a, 0);
  endtask

  task automatic test_source_select();
    ntp_time_t   t;
    ntp_time_t   exp_time;
    clk_sel_t    src;
    clk_sel_t    exp_src;
    logic        syn;
    int unsigned cap;
    int unsigned start;
    int          round;
    int          i;
    // Round 0 pulses B alone, round 1 pulses both
    for (round = 0; round < 2; round++) begin
      for (i = 0; i < 4; i++) begin
        start = cycle_cnt;
        pps_pulse(round == 1, 1'b1, 4);
        wait_until_cycle(start + 12);
        if (i == 3) begin
          request_timestamp(t, src, syn, cap);
          exp_src = (round == 1) ? CLK_A : CLK_B;
          if (src !== exp_src) report_mismatch("ts_source", src, exp_src);
          if (syn !== 1'b1) report_mismatch("ts_synced", syn, 1);
          if (round == 0) begin
            // Clock B took the pending load at its first event, then one second per event
            exp_time.sec  = loaded_sec + ntp_sec_t'(i);
            exp_time.frac = ntp_frac_t'(cap - start - PPS_MIN_CYCLES - 5) * FRAC_STEP;
            if (t !== exp_time) report_mismatch("ts_time", t, exp_time);
          end
        end
        wait_until_cycle(start + SEC_CYCLES);
        if (i > 0) begin
          if (sync_ok_b !== 1'b1) report_mismatch("sync_ok_b", sync_ok_b, 1);
          if (sync_ok_a !== logic'(round == 1)) report_mismatch("sync_ok_a", sync_ok_a, round);
        end
      end
    end
    // With PPS stopped both flags must time out
    while ((sync_ok_a || sync_ok_b) && cycle_cnt < start + 6 + PPS_TIMEOUT + 8) next_cycle();
    if (sync_ok_a || sync_ok_b) report_problem("sync flags still high after PPS stopped");
    request_timestamp(t, src, syn, cap);
    if (src !== CLK_A) report_mismatch("ts_source", src, CLK_A);
    if (syn !== 1'b0) report_mismatch("ts_synced", syn, 0);
  endtask

  // --------------------
  // Main sequence and watchdog
  // --------------------
  initial begin
    clk156 = 1'b0;
    rst_n = 1'b0;
    pps_a = 1'b0;
    pps_b = 1'b0;
    sec_set = 1'b0;
    sec_value = '0;
    ts_req = 1'b0;
    cycle_cnt = 0;
    lcg_state = 52;
    mismatch_count = 0;
    problem_count = 0;
    repeat (RESET_CYCLES) @(posedge clk156);
    #1;
    rst_n = 1'b1;
    release_cycle = cycle_cnt;
    test_reset_handshake();
    test_counting();
    test_seconds_load();
    test_glitch_and_sync();
    test_source_select();
    $display("Value errors: %0d, other failures: %0d", mismatch_count, problem_count);
    if (mismatch_count + problem_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(BUDGET_CYCLES * CLK_PERIOD);
    $display("Error: run did not finish within %0d cycles", BUDGET_CYCLES);
    $display("Value errors: %0d, other failures: %0d", mismatch_count, problem_count + 1);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* source/ntps_core.sv */
// NTP server timekeeping core

module ntps_core #(
  // Default step is about 2^32 / 156.25 MHz
  parameter ntps_pkg::ntp_frac_t FRAC_STEP      = 32'd27,
  parameter int                  PPS_MIN_CYCLES = 1000,
  parameter ntps_pkg::ntp_frac_t SYNC_TOL       = 32'd4295,
  parameter int                  PPS_TIMEOUT    = 160_000_000
) (
  input  logic                clk156,
  input  logic                rst_n,
  input  logic                pps_a,
  input  logic                pps_b,
  input  logic                sec_set,
  input  ntps_pkg::ntp_sec_t  sec_value,
  input  logic                ts_req,
  output logic                ts_ack,
  output ntps_pkg::ntp_time_t ts_time,
  output ntps_pkg::clk_sel_t  ts_source,
  output logic                ts_synced,
  output logic                sync_ok_a,
  output logic                sync_ok_b
);

  import ntps_pkg::*;

  ntp_time_t time_a;
  ntp_time_t time_b;

  // --------------------
  // NTP clocks
  // --------------------
  ntp_clock #(
    .FRAC_STEP      (FRAC_STEP),
    .PPS_MIN_CYCLES (PPS_MIN_CYCLES),
    .SYNC_TOL       (SYNC_TOL),
    .PPS_TIMEOUT    (PPS_TIMEOUT)
  ) clock_a (
    .clk156    (clk156),
    .rst_n     (rst_n),
    .pps       (pps_a),
    .sec_set   (sec_set),
    .sec_value (sec_value),
    .ntp_time  (time_a),
    .sync_ok   (sync_ok_a)
  );

  ntp_clock #(
    .FRAC_STEP      (FRAC_STEP),
    .PPS_MIN_CYCLES (PPS_MIN_CYCLES),
    .SYNC_TOL       (SYNC_TOL),
    .PPS_TIMEOUT    (PPS_TIMEOUT)
  ) clock_b (
    .clk156    (clk156),
    .rst_n     (rst_n),
    .pps       (pps_b),
    .sec_set   (sec_set),
    .sec_value (sec_value),
    .ntp_time  (time_b),
    .sync_ok   (sync_ok_b)
  );

  // --------------------
  // Timestamp server
  // --------------------
  timestamp_server ts_server (
    .clk156    (clk156),
    .rst_n     (rst_n),
    .time_a    (time_a),
    .time_b    (time_b),
    .sync_ok_a (sync_ok_a),
    .sync_ok_b (sync_ok_b),
    .ts_req    (ts_req),
    .ts_ack    (ts_ack),
    .ts_time   (ts_time),
    .ts_source (ts_source),
    .ts_synced (ts_synced)
  );

endmodule

/* source/timestamp_server.sv */
// Timestamp request server

module timestamp_server (
  input  logic                clk156,
  input  logic                rst_n,
  input  ntps_pkg::ntp_time_t time_a,
  input  ntps_pkg::ntp_time_t time_b,
  input  logic                sync_ok_a,
  input  logic                sync_ok_b,
  input  logic                ts_req,
  output logic                ts_ack,
  output ntps_pkg::ntp_time_t ts_time,
  output ntps_pkg::clk_sel_t  ts_source,
  output logic                ts_synced
);

  import ntps_pkg::*;

  clk_sel_t  sel_src;
  ntp_time_t sel_time;
  logic      sel_sync;

  // --------------------
  // Source selection
  // --------------------
  // A is preferred, B only when it alone is in sync
  always_comb begin
    if (sync_ok_b && !sync_ok_a) begin
      sel_src  = CLK_B;
      sel_time = time_b;
      sel_sync = sync_ok_b;
    end else begin
      sel_src  = CLK_A;
      sel_time = time_a;
      sel_sync = sync_ok_a;
    end
  end

  // --------------------
  // Four-phase handshake
  // --------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      ts_ack    <= 1'b0;
      ts_time   <= '0;
      ts_source <= CLK_A;
      ts_synced <= 1'b0;
    end else if (!ts_ack) begin
      if (ts_req) begin
        ts_ack    <= 1'b1;
        ts_time   <= sel_time;
        ts_source <= sel_src;
        ts_synced <= sel_sync;
      end
    end else if (!ts_req) begin
      // Drop ack and keep the captured values until the next request
      ts_ack <= 1'b0;
    end
  end

  a_ack_on_req: assert property (@(posedge clk156) disable iff (!rst_n)
    $rose(ts_ack) |-> $past(ts_req))
    else $error("ts_ack rose without a request");

  a_time_frozen: assert property (@(posedge clk156) disable iff (!rst_n)
    (ts_ack && $past(ts_ack)) |-> $stable(ts_time))
    else $error("ts_time changed while ts_ack held high");

endmodule

/* source/ntp_clock.sv */
// NTP clock with PPS discipline

module ntp_clock #(
  parameter ntps_pkg::ntp_frac_t FRAC_STEP      = 32'd27,
  parameter int                  PPS_MIN_CYCLES = 1000,
  parameter ntps_pkg::ntp_frac_t SYNC_TOL       = 32'd4295,
  parameter int                  PPS_TIMEOUT    = 160_000_000
) (
  input  logic                clk156,
  input  logic                rst_n,
  input  logic                pps,
  input  logic                sec_set,
  input  ntps_pkg::ntp_sec_t  sec_value,
  output ntps_pkg::ntp_time_t ntp_time,
  output logic                sync_ok
);

  import ntps_pkg::*;

  localparam int IDLE_W = $clog2(PPS_TIMEOUT + 1);

  logic              pps_event;
  ntp_sec_t          sec_q;
  ntp_frac_t         frac_q;
  logic [NTP_FRAC_W:0] frac_sum;
  ntp_frac_t         phase_err;
  ntp_sec_t          load_sec;
  logic              load_pending;
  logic              seen_event;
  logic [IDLE_W-1:0] idle_cnt;

  pps_sync #(
    .PPS_MIN_CYCLES (PPS_MIN_CYCLES)
  ) pps_in (
    .clk156    (clk156),
    .rst_n     (rst_n),
    .pps       (pps),
    .pps_event (pps_event)
  );

  // Carry out of the fraction lands in the top bit
  assign frac_sum = {1'b0, frac_q} + {1'b0, FRAC_STEP};

  // Distance from the current fraction to the nearest whole second
  assign phase_err = frac_q[NTP_FRAC_W-1] ? (~frac_q + 1'b1) : frac_q;

  assign ntp_time = {sec_q, frac_q};

  // --------------------
  // Time counter
  // --------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      sec_q  <= '0;
      frac_q <= '0;
    end else if (pps_event) begin
      frac_q <= '0;
      if (load_pending) begin
        sec_q <= load_sec;
      end else if (frac_q[NTP_FRAC_W-1]) begin
        // Running slow so the edge belongs to the next second
        sec_q <= sec_q + 1'b1;
      end
    end else begin
      frac_q <= frac_sum[NTP_FRAC_W-1:0];
      if (frac_sum[NTP_FRAC_W]) begin
        sec_q <= sec_q + 1'b1;
      end
    end
  end

  // Seconds value waiting for the next PPS edge
  always_ff @(posedge clk156) begin
    if (sec_set) begin
      load_sec <= sec_value;
    end
  end

  // --------------------
  // Load and sync status
  // --------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      load_pending <= 1'b0;
      seen_event   <= 1'b0;
      idle_cnt     <= '0;
      sync_ok      <= 1'b0;
    end else begin
      if (sec_set) begin
        load_pending <= 1'b1;
      end else if (pps_event) begin
        load_pending <= 1'b0;
      end

      if (pps_event) begin
        seen_event <= 1'b1;
        idle_cnt   <= '0;
        if (phase_err > SYNC_TOL) begin
          sync_ok <= 1'b0;
        end else if (seen_event) begin
          sync_ok <= 1'b1;
        end
      end else if (idle_cnt == IDLE_W'(PPS_TIMEOUT)) begin
        // PPS lost
        sync_ok <= 1'b0;
      end else begin
        idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

  a_sec_step: assert property (@(posedge clk156) disable iff (!rst_n)
    $changed(sec_q) |-> $past(frac_sum[NTP_FRAC_W] || pps_event))
    else $error("seconds changed without carry or PPS event");

endmodule

/* source/pps_sync.sv */
// PPS input conditioner

module pps_sync #(
  parameter int PPS_MIN_CYCLES = 1000
) (
  input  logic clk156,
  input  logic rst_n,
  input  logic pps,
  output logic pps_event
);

  // Room to count one past the threshold, then hold
  localparam int CNT_W = $clog2(PPS_MIN_CYCLES + 2);

  logic             pps_meta;
  logic             pps_sync_q;
  logic [CNT_W-1:0] width_cnt;

  // --------------------
  // Synchronizer and width filter
  // --------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      pps_meta   <= 1'b0;
      pps_sync_q <= 1'b0;
      width_cnt  <= '0;
      pps_event  <= 1'b0;
    end else begin
      pps_meta   <= pps;
      pps_sync_q <= pps_meta;

      // Count high cycles, restart on low, saturate past the threshold
      if (!pps_sync_q) begin
        width_cnt <= '0;
      end else if (width_cnt != CNT_W'(PPS_MIN_CYCLES + 1)) begin
        width_cnt <= width_cnt + 1'b1;
      end

      // Only passes through the threshold value once per pulse
      pps_event <= (width_cnt == CNT_W'(PPS_MIN_CYCLES));
    end
  end

  a_single_event: assert property (@(posedge clk156) disable iff (!rst_n)
    pps_event |=> !pps_event)
    else $error("pps_event held for more than one cycle");

endmodule

/* source/ntps_pkg.sv */
// NTP timekeeping types

package ntps_pkg;

  // --------------------
  // Field widths
  // --------------------
  parameter int NTP_SEC_W  = 32;
  parameter int NTP_FRAC_W = 32;

  // Seconds since the NTP epoch
  typedef logic [NTP_SEC_W-1:0] ntp_sec_t;

  // Fraction of a second in units of 2^-32 s
  typedef logic [NTP_FRAC_W-1:0] ntp_frac_t;

  // --------------------
  // Full timestamp
  // --------------------
  // Seconds in the upper half, fraction in the lower half
  typedef struct packed {
    ntp_sec_t  sec;
    ntp_frac_t frac;
  } ntp_time_t;

  // Which of the two clocks a timestamp came from
  typedef enum logic {
    CLK_A = 1'b0,
    CLK_B = 1'b1
  } clk_sel_t;

endpackage
